/* hw/line_buf_pkg.sv */
// line buffer shared sizes, pixel and window types, stream structs and frame states
package line_buf_pkg;

  localparam int PIX_DW    = 8;
  localparam int KRNV_SZ   = 5;                 // vertical kernel size, odd
  localparam int KRN_HALF  = (KRNV_SZ - 1) / 2; // padding rows on each side
  localparam int MAX_WIDTH = 64;
  localparam int COL_AW    = $clog2(MAX_WIDTH);
  localparam int ROW_CW    = $clog2(KRN_HALF + 2); // row and padding-row counters

  typedef logic [PIX_DW-1:0] pixel_t;

  // stored lines of one column, index 0 is the newest line
  typedef pixel_t [KRNV_SZ-2:0] column_t;

  // msb is the oldest row, lsb the newest
  typedef pixel_t [KRNV_SZ-1:0] window_t;

  typedef struct packed {
    logic   href;
    logic   hend;
    logic   vstr;
    logic   vend;
    pixel_t data;
  } pix_strm_t;

  typedef struct packed {
    logic    dvld;
    logic    hstr;
    logic    hend;
    logic    vstr;
    logic    vend;
    window_t data;
  } win_strm_t;

  // one request per pixel, input or bottom padding
  typedef struct packed {
    logic              valid;
    logic [COL_AW-1:0] addr;
    pixel_t            data;
    logic              seed;   // row 0, fill column with this pixel
    logic              repl;   // padding row, reuse stored newest pixel
    logic              out_en;
    logic              hstr;
    logic              hend;
    logic              vstr;
    logic              vend;
  } pix_req_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_FILL,
    FS_ACTIVE,
    FS_BTM_PAD
  } frame_state_e;

endpackage

/* hw/frame_seq.sv */
// frame sequencer: row and column counting, frame FSM and bottom padding request generation
module frame_seq (
  input  logic                    clk,
  input  logic                    rst_n,
  input  line_buf_pkg::pix_strm_t i_pix,
  output line_buf_pkg::pix_req_t  o_req
);

  line_buf_pkg::frame_state_e state;
  line_buf_pkg::frame_state_e state_nxt;

  logic [line_buf_pkg::ROW_CW-1:0] row_cnt;  // saturates one past the first output row
  logic [line_buf_pkg::COL_AW-1:0] col_cnt;
  logic [line_buf_pkg::COL_AW-1:0] last_col; // width-1, taken from row 0
  logic [line_buf_pkg::ROW_CW-1:0] pad_cnt;
  logic                            pad_gap;  // idle cycle between padding rows

  logic take;       // input pixel accepted
  logic pad_issue;  // padding pixel issued this cycle
  logic pad_last;
  logic pad_done;   // last pixel of last padding row
  logic fill_end;
  logic first_out;

  // pixels during bottom padding are dropped
  assign take = i_pix.href &
                (((state == line_buf_pkg::FS_IDLE) & i_pix.vstr) |
                 (state == line_buf_pkg::FS_FILL) |
                 (state == line_buf_pkg::FS_ACTIVE));

  assign pad_issue = (state == line_buf_pkg::FS_BTM_PAD) & ~pad_gap;
  assign pad_last  = (col_cnt == last_col);
  assign pad_done  = pad_issue & pad_last &
                     (pad_cnt == line_buf_pkg::ROW_CW'(line_buf_pkg::KRN_HALF - 1));

  assign fill_end  = take & i_pix.hend &
                     (row_cnt == line_buf_pkg::ROW_CW'(line_buf_pkg::KRN_HALF - 1));
  assign first_out = (state == line_buf_pkg::FS_ACTIVE) &
                     (row_cnt == line_buf_pkg::ROW_CW'(line_buf_pkg::KRN_HALF)) &
                     (col_cnt == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      line_buf_pkg::FS_IDLE: begin
        if (take) state_nxt = line_buf_pkg::FS_FILL;
      end
      line_buf_pkg::FS_FILL: begin
        if (fill_end) state_nxt = line_buf_pkg::FS_ACTIVE;
      end
      line_buf_pkg::FS_ACTIVE: begin
        if (take & i_pix.vend) state_nxt = line_buf_pkg::FS_BTM_PAD;
      end
      line_buf_pkg::FS_BTM_PAD: begin
        if (pad_done) state_nxt = line_buf_pkg::FS_IDLE;
      end
      default: state_nxt = line_buf_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= line_buf_pkg::FS_IDLE;
      row_cnt  <= '0;
      col_cnt  <= '0;
      last_col <= '0;
      pad_cnt  <= '0;
      pad_gap  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (take) begin
        if (i_pix.hend) begin
          col_cnt <= '0;
          if (row_cnt == '0) last_col <= col_cnt; // row width learned here
          if (row_cnt != line_buf_pkg::ROW_CW'(line_buf_pkg::KRN_HALF + 1)) begin
            row_cnt <= row_cnt + 1'b1;
          end
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
        if (i_pix.vend) begin
          col_cnt <= '0;
          pad_cnt <= '0;
          pad_gap <= 1'b0; // first padding row right after vend
        end
      end else if (pad_issue) begin
        if (pad_done) begin
          col_cnt <= '0;
          row_cnt <= '0;   // ready for next frame
        end else if (pad_last) begin
          col_cnt <= '0;
          pad_cnt <= pad_cnt + 1'b1;
          pad_gap <= 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end else if (pad_gap) begin
        pad_gap <= 1'b0;
      end
    end
  end

  // request to memory and assembler
  always_comb begin
    o_req = '0;
    if (take) begin
      o_req.valid  = 1'b1;
      o_req.addr   = col_cnt;
      o_req.data   = i_pix.data;
      o_req.seed   = (row_cnt == '0);
      o_req.out_en = (state == line_buf_pkg::FS_ACTIVE);
      o_req.hstr   = (col_cnt == '0);
      o_req.hend   = i_pix.hend;
      o_req.vstr   = first_out;
    end else if (pad_issue) begin
      o_req.valid  = 1'b1;
      o_req.addr   = col_cnt;
      o_req.repl   = 1'b1;      // duplicate the last input row
      o_req.out_en = 1'b1;
      o_req.hstr   = (col_cnt == '0);
      o_req.hend   = pad_last;
      o_req.vend   = pad_done;
    end
  end

endmodule

/* hw/line_mem.sv */
// column memory of the line buffer with registered read and one write port
module line_mem (
  input  logic                            clk,
  input  logic                            i_rd_en,
  input  logic [line_buf_pkg::COL_AW-1:0] i_rd_addr,
  output line_buf_pkg::column_t           o_rd_col,
  input  logic                            i_wr_en,
  input  logic [line_buf_pkg::COL_AW-1:0] i_wr_addr,
  input  line_buf_pkg::column_t           i_wr_col
);

  // one word per image column, holds KRNV_SZ-1 lines
  line_buf_pkg::column_t mem [line_buf_pkg::MAX_WIDTH];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_col;
    end
  end

  // data valid one cycle after the request
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_col <= mem[i_rd_addr];
    end
  end

endmodule

/* hw/window_asm.sv */
// window assembler: aligns read column with request, builds window and write-back column
module window_asm (
  input  logic                            clk,
  input  logic                            rst_n,
  input  line_buf_pkg::pix_req_t          i_req,
  input  line_buf_pkg::column_t           i_rd_col,
  output logic                            o_wr_en,
  output logic [line_buf_pkg::COL_AW-1:0] o_wr_addr,
  output line_buf_pkg::column_t           o_wr_col,
  output line_buf_pkg::win_strm_t         o_win
);

  line_buf_pkg::pix_req_t  req_q;    // lines up with memory read data
  line_buf_pkg::pixel_t    newest;
  line_buf_pkg::column_t   col_use;
  line_buf_pkg::window_t   win_nxt;
  logic                    load;

  logic                    dvld_q;
  logic                    hstr_q;
  logic                    hend_q;
  logic                    vstr_q;
  logic                    vend_q;
  line_buf_pkg::window_t   data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= i_req;
    end
  end

  always_comb begin
    // padding rows repeat whatever is newest in the column
    newest = req_q.repl ? i_rd_col[0] : req_q.data;
    if (req_q.seed) begin
      col_use = {(line_buf_pkg::KRNV_SZ - 1){req_q.data}}; // first row, memory not valid yet
    end else begin
      col_use = i_rd_col;
    end
    win_nxt = {col_use, newest};
  end

  // oldest entry drops out, newest pixel goes in at the bottom
  assign o_wr_en   = req_q.valid;
  assign o_wr_addr = req_q.addr;
  assign o_wr_col  = {col_use[line_buf_pkg::KRNV_SZ-3:0], newest};

  assign load = req_q.valid & req_q.out_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dvld_q <= 1'b0;
      hstr_q <= 1'b0;
      hend_q <= 1'b0;
      vstr_q <= 1'b0;
      vend_q <= 1'b0;
    end else if (load) begin
      dvld_q <= 1'b1;
      hstr_q <= req_q.hstr;
      hend_q <= req_q.hend;
      vstr_q <= req_q.vstr;
      vend_q <= req_q.vend;
    end else begin
      dvld_q <= 1'b0;
      hstr_q <= 1'b0;
      hend_q <= 1'b0;
      vstr_q <= 1'b0;
      vend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= win_nxt;
    end
  end

  assign o_win = '{
    dvld: dvld_q,
    hstr: hstr_q,
    hend: hend_q,
    vstr: vstr_q,
    vend: vend_q,
    data: data_q
  };

endmodule

/* hw/line_buf_top.sv */
// line buffer top: sequencer, column memory and window assembler for a vertical kernel
module line_buf_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  line_buf_pkg::pix_strm_t i_pix,
  output line_buf_pkg::win_strm_t o_win
);

  line_buf_pkg::pix_req_t  req;
  line_buf_pkg::column_t   rd_col;
  line_buf_pkg::column_t   wr_col;
  logic                    wr_en;
  logic [line_buf_pkg::COL_AW-1:0] wr_addr;

  // row/column tracking and padding generation
  frame_seq u_frame_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .i_pix (i_pix),
    .o_req (req)
  );

  // one column per image x position
  line_mem u_line_mem (
    .clk       (clk),
    .i_rd_en   (req.valid),
    .i_rd_addr (req.addr),
    .o_rd_col  (rd_col),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_col  (wr_col)
  );

  // window out, shifted column written back
  window_asm u_window_asm (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_req     (req),
    .i_rd_col  (rd_col),
    .o_wr_en   (wr_en),
    .o_wr_addr (wr_addr),
    .o_wr_col  (wr_col),
    .o_win     (o_win)
  );

endmodule

/* test/line_buf_model.svh */
// line buffer reference model: stored input frame and expected windows with edge row duplication
`ifndef LINE_BUF_MODEL_SVH
`define LINE_BUF_MODEL_SVH

localparam int MODEL_MAX_H = 12; // tallest frame the stimulus sends

// input frame as sent, one entry per row and column
line_buf_pkg::pixel_t frame_pix [MODEL_MAX_H][line_buf_pkg::MAX_WIDTH];
int frame_w;
int frame_h;

function automatic void begin_frame(int w, int h);
  frame_w = w;
  frame_h = h;
endfunction

function automatic void store_pixel(int row, int col, line_buf_pkg::pixel_t pix);
  frame_pix[row][col] = pix;
endfunction

// rows above and below the frame repeat the edge row
function automatic int clamp_row(int row);
  if (row < 0) begin
    return 0;
  end else if (row > frame_h - 1) begin
    return frame_h - 1;
  end else begin
    return row;
  end
endfunction

// oldest row in the top pixel, newest in the bottom one
function automatic line_buf_pkg::window_t expected_window(int out_row, int col);
  line_buf_pkg::window_t win;
  int src;
  for (int k = 0; k < line_buf_pkg::KRNV_SZ; k++) begin
    src = clamp_row(out_row - line_buf_pkg::KRN_HALF + k);
    win[line_buf_pkg::KRNV_SZ-1-k] = frame_pix[src][col];
  end
  return win;
endfunction

function automatic int pixel_count();
  return frame_w * frame_h;
endfunction

// flags for output pixel idx, packed as {hstr, hend, vstr, vend}
function automatic logic [3:0] expected_flags(int idx);
  int col;
  logic [3:0] flags;
  col = idx % frame_w;
  flags[3] = (col == 0);
  flags[2] = (col == frame_w - 1);
  flags[1] = (idx == 0);
  flags[0] = (idx == pixel_count() - 1);
  return flags;
endfunction

// output rows whose newest pixel is a real input pixel, the rest are bottom padding
function automatic logic fed_by_input(int out_row);
  return (out_row < frame_h - line_buf_pkg::KRN_HALF);
endfunction

// which edge handling an output row goes through
function automatic string row_region(int out_row);
  if (out_row < line_buf_pkg::KRN_HALF) begin
    return "top pad";
  end else if (out_row > frame_h - 1 - line_buf_pkg::KRN_HALF) begin
    return "bottom pad";
  end else begin
    return "interior";
  end
endfunction

`endif

/* test/line_buf_tb.sv */
// line buffer testbench: random frames from an LFSR, checked against the frame model
module line_buf_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_FRAMES  = 8;
  localparam int END_TIMEOUT = 2000; // cycles allowed for the frame end after the last input

  logic                    clk;
  logic                    rst_n;
  line_buf_pkg::pix_strm_t pix_in;
  line_buf_pkg::win_strm_t win_out;

  logic [31:0] lfsr;
  time         in_time_q[$]; // drive times of input pixels that produce an output
  int          out_idx;
  int          frames_done;
  int          check_cnt;
  int          err_cnt;
  int          timeouts;

  `include "line_buf_model.svh"

  line_buf_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .i_pix (pix_in),
    .o_win (win_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic int rand_range(int lo, int hi, int nbits);
    return lo + (int'(take_bits(nbits)) % (hi - lo + 1));
  endfunction

  task automatic send_frame(int w, int h);
    line_buf_pkg::pix_strm_t nxt;
    line_buf_pkg::pixel_t    pix;
    int                      gap;
    begin_frame(w, h);
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        pix = line_buf_pkg::pixel_t'(take_bits(line_buf_pkg::PIX_DW));
        store_pixel(r, c, pix);
        nxt.href = 1'b1;
        nxt.hend = (c == w - 1);
        nxt.vstr = (r == 0) && (c == 0);
        nxt.vend = (r == h - 1) && (c == w - 1);
        nxt.data = pix;
        @(posedge clk);
        pix_in <= nxt;
        if (r >= line_buf_pkg::KRN_HALF) in_time_q.push_back($time);
      end
      gap = rand_range(1, 3, 2); // idle cycles after the row
      repeat (gap) begin
        @(posedge clk);
        pix_in <= '0;
      end
    end
  endtask

  task automatic compare_flag(string name, logic exp, logic got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s exp=%0b got=%0b", $time, name, exp, got);
    end
  endtask

  task automatic check_output();
    line_buf_pkg::window_t exp_win;
    logic [3:0]            flags;
    int                    row;
    int                    col;
    time                   t_in;
    if (!win_out.dvld) begin
      if (win_out.hstr | win_out.hend | win_out.vstr | win_out.vend) begin
        err_cnt++;
        $display("output flags set at %0t while dvld is low", $time);
      end
    end else if (out_idx >= pixel_count()) begin
      err_cnt++;
      $display("extra output pixel at %0t beyond the %0d of the frame", $time, pixel_count());
    end else begin
      row     = out_idx / frame_w;
      col     = out_idx % frame_w;
      exp_win = expected_window(row, col);
      flags   = expected_flags(out_idx);
      check_cnt++;
      if (win_out.data !== exp_win) begin
        err_cnt++;
        $display("[ERROR] %0t o_win.data row %0d col %0d (%s) exp=%h got=%h",
                 $time, row, col, row_region(row), exp_win, win_out.data);
      end
      compare_flag("o_win.hstr", flags[3], win_out.hstr);
      compare_flag("o_win.hend", flags[2], win_out.hend);
      compare_flag("o_win.vstr", flags[1], win_out.vstr);
      compare_flag("o_win.vend", flags[0], win_out.vend);
      // two edges after the driving edge, seen here half a period later
      if (fed_by_input(row)) begin
        if (in_time_q.size() == 0) begin
          err_cnt++;
          $display("output pixel at %0t has no matching input pixel", $time);
        end else begin
          t_in = in_time_q.pop_front();
          check_cnt++;
          if ($time != t_in + 2 * CLK_PERIOD + CLK_PERIOD / 2) begin
            err_cnt++;
            $display("[ERROR] %0t o_win.dvld time exp=%0t got=%0t", $time,
                     t_in + 2 * CLK_PERIOD + CLK_PERIOD / 2, $time);
          end
        end
      end
      out_idx++;
      if (win_out.vend) begin
        check_cnt++;
        if (out_idx != pixel_count()) begin
          err_cnt++;
          $display("[ERROR] %0t o_win.dvld count exp=%0d got=%0d", $time, pixel_count(), out_idx);
        end
        if (in_time_q.size() != 0) begin
          err_cnt++;
          $display("%0d input pixels of the frame never came out", in_time_q.size());
          in_time_q.delete();
        end
        out_idx = 0;
        frames_done++;
      end
    end
  endtask

  // sample on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (rst_n) check_output();
  end

  initial begin
    int w;
    int h;
    int wait_cyc;
    lfsr        = 32'hc0e3_c66c;
    out_idx     = 0;
    frames_done = 0;
    check_cnt   = 0;
    err_cnt     = 0;
    timeouts    = 0;
    rst_n       = 1'b0;
    pix_in      = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
      w = rand_range(2, line_buf_pkg::MAX_WIDTH, 6);
      h = rand_range(line_buf_pkg::KRN_HALF + 1, MODEL_MAX_H, 4);
      if (f == 1) h = line_buf_pkg::KRN_HALF + 1; // shortest legal frame
      if (f == 2) w = line_buf_pkg::MAX_WIDTH;
      if (f == 3) w = 2;
      send_frame(w, h);
      // next frame only after the previous vend
      wait_cyc = 0;
      while (frames_done == f && wait_cyc < END_TIMEOUT) begin
        @(posedge clk);
        wait_cyc++;
      end
      if (frames_done == f) begin
        timeouts++;
        $display("timeout: frame %0d of %0dx%0d pixels never signalled its end", f, w, h);
      end
    end

    repeat (4) @(posedge clk);
    $display("summary: %0d frames, %0d checks, %0d errors, %0d timeouts",
             frames_done, check_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* line_buf_top.f */
+incdir+test
hw/line_buf_pkg.sv
hw/frame_seq.sv
hw/line_mem.sv
hw/window_asm.sv
hw/line_buf_top.sv
test/line_buf_tb.sv

/* Makefile */
TOP = line_buf_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): line_buf_top.f $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing -j 0 --top-module $(TOP) -f line_buf_top.f -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
